//--- design/rp_pkg.sv
// Shared constants and types for the single-domain ADC to DAC data path.
// Imported by every RTL module and by the testbench. Holds the register map,
// the AXI4-Lite channel structs and the slope conversion used on both sides.
package rp_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int ADC_RAW_W = 16;  // Pin word, two reserved LSBs
  localparam int SMP_W     = 14;  // Converter resolution
  localparam int AXI_AW    = 8;
  localparam int AXI_DW    = 32;

  typedef logic signed [SMP_W-1:0] sample_t;

  // Both channels side by side, A in the upper half
  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  typedef enum logic {
    MODE_PASS = 1'b0,  // Mixer value straight out
    MODE_AVG  = 1'b1   // Moving average over the window
  } out_mode_e;

  ////////////////////////////////////////
  // Register map and bus
  ////////////////////////////////////////

  typedef enum logic [AXI_AW-1:0] {
    REG_ID      = 8'h00,  // Read only
    REG_CTRL    = 8'h04,  // Loop and output modes
    REG_LEVEL_A = 8'h08,
    REG_LEVEL_B = 8'h0C
  } reg_addr_e;

  typedef struct packed {
    logic      digital_loop;
    out_mode_e mode_a;
    out_mode_e mode_b;
    sample_t   level_a;  // Stands in for generator plus controller
    sample_t   level_b;
  } cfg_t;

  // Master driven side
  typedef struct packed {
    logic                awvalid;
    logic [AXI_AW-1:0]   awaddr;
    logic                wvalid;
    logic [AXI_DW-1:0]   wdata;
    logic [AXI_DW/8-1:0] wstrb;
    logic                bready;
    logic                arvalid;
    logic [AXI_AW-1:0]   araddr;
    logic                rready;
  } axil_req_t;

  // Slave driven side
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Negative slope <-> two's complement, same operation both ways
  function automatic sample_t flip_slope(input logic [SMP_W-1:0] code);
    return sample_t'({code[SMP_W-1], ~code[SMP_W-2:0]});
  endfunction

endpackage

//--- design/adc_frontend.sv
// Input register stage of the fast path.
// Drops the reserved low bits of each ADC word and turns the negative-slope
// code into two's complement. In loopback the mixer result is taken instead
// of the pins, so the whole chain can be exercised without analog input.
module adc_frontend import rp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 adc_rstn,
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,  // Raw pin word, channel A
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,  // Raw pin word, channel B
  input  cfg_t                 cfg_i,
  input  sample_pair_t         mix_smp_i,    // Loopback source
  output sample_pair_t         adc_smp_o
);

  ////////////////////////////////////////
  // Pin decode
  ////////////////////////////////////////

  sample_pair_t pin_smp;  // Converted pin data
  sample_pair_t smp_q;

  // Top 14 bits only, then sign kept and rest inverted
  assign pin_smp.ch_a = flip_slope(adc_dat_a_i[ADC_RAW_W-1 -: SMP_W]);
  assign pin_smp.ch_b = flip_slope(adc_dat_b_i[ADC_RAW_W-1 -: SMP_W]);

  ////////////////////////////////////////
  // Sample register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      smp_q <= '0;
    end else if (cfg_i.digital_loop) begin
      smp_q <= mix_smp_i;  // Previous cycle's mixer output
    end else begin
      smp_q <= pin_smp;
    end
  end

  assign adc_smp_o = smp_q;

  // Clean start for the mixer and the average history
  a_zero_after_reset: assert property (
    @(posedge adc_clk) !adc_rstn |=> (adc_smp_o == '0)
  ) else $error("adc_frontend: sample not cleared by reset");

endmodule

//--- design/axil_regs.sv
// AXI4-Lite register slave for the data path.
// Holds the identification word, control bits and the two level registers.
// Write and read channels run independently, one outstanding response each.
// Unknown addresses and writes to the ID word answer with SLVERR.
module axil_regs import rp_pkg::*; #(
  parameter logic [AXI_DW-1:0] ID_VALUE = 32'h5250_0001
) (
  input  logic      adc_clk,
  input  logic      adc_rstn,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output cfg_t      cfg_o
);

  cfg_t              cfg_q;
  logic              bvalid_q;
  logic [1:0]        bresp_q;
  logic              rvalid_q;
  logic [AXI_DW-1:0] rdata_q;
  logic [1:0]        rresp_q;

  logic              wr_take;  // Address and data taken this cycle
  logic              wr_ok;
  logic              rd_take;
  logic              rd_ok;
  logic [AXI_DW-1:0] rd_word;

  ////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////

  // Both halves together, only when no response is waiting
  assign wr_take = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
  assign wr_ok   = axil_req_i.awaddr inside {REG_CTRL, REG_LEVEL_A, REG_LEVEL_B};

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      cfg_q    <= '0;  // Loop off, pass mode, zero levels
      bvalid_q <= 1'b0;
    end else if (wr_take) begin
      bvalid_q <= 1'b1;
      case (axil_req_i.awaddr)
        REG_CTRL: begin
          cfg_q.digital_loop <= axil_req_i.wdata[0];
          cfg_q.mode_a       <= out_mode_e'(axil_req_i.wdata[1]);
          cfg_q.mode_b       <= out_mode_e'(axil_req_i.wdata[2]);
        end
        REG_LEVEL_A: cfg_q.level_a <= axil_req_i.wdata[SMP_W-1:0];  // Low bits only
        REG_LEVEL_B: cfg_q.level_b <= axil_req_i.wdata[SMP_W-1:0];
        default: ;  // ID and holes left alone
      endcase
    end else if (bvalid_q && axil_req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (wr_take) begin
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  ////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////

  assign rd_take = axil_req_i.arvalid & ~rvalid_q;

  // Read mux
  always_comb begin
    rd_word = '0;
    rd_ok   = 1'b1;
    case (axil_req_i.araddr)
      REG_ID:      rd_word = ID_VALUE;
      REG_CTRL:    rd_word = {{(AXI_DW-3){1'b0}}, cfg_q.mode_b, cfg_q.mode_a,
                              cfg_q.digital_loop};
      REG_LEVEL_A: rd_word = {{(AXI_DW-SMP_W){cfg_q.level_a[SMP_W-1]}}, cfg_q.level_a};
      REG_LEVEL_B: rd_word = {{(AXI_DW-SMP_W){cfg_q.level_b[SMP_W-1]}}, cfg_q.level_b};
      default:     rd_ok   = 1'b0;  // Reads back zero
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      rvalid_q <= 1'b0;
    end else if (rd_take) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rd_take) begin
      rdata_q <= rd_word;
      rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign axil_rsp_o.awready = wr_take;  // Single cycle pulse
  assign axil_rsp_o.wready  = wr_take;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.arready = ~rvalid_q;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;

  assign cfg_o = cfg_q;

  a_bvalid_hold: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    bvalid_q && !axil_req_i.bready |=> bvalid_q
  ) else $error("axil_regs: write response dropped before bready");

  a_rdata_hold: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q)
  ) else $error("axil_regs: read data changed under back-pressure");

endmodule

//--- design/dac_mixer.sv
// Mixer stage between the ADC front end and the DAC output side.
// Adds the per-channel level register to each sample, saturates the 15-bit
// sum back to 14 bits and registers the result. The output also feeds the
// front end for digital loopback.
module dac_mixer import rp_pkg::*; (
  input  logic         adc_clk,
  input  logic         adc_rstn,
  input  cfg_t         cfg_i,
  input  sample_pair_t adc_smp_i,
  output sample_pair_t mix_smp_o
);

  // Clamp to the 14-bit range when the two top bits disagree
  function automatic sample_t sat14(input logic signed [SMP_W:0] s);
    return (s[SMP_W] ^ s[SMP_W-1]) ? sample_t'({s[SMP_W], {(SMP_W-1){~s[SMP_W]}}})
                                   : s[SMP_W-1:0];
  endfunction

  ////////////////////////////////////////
  // Sum and saturation
  ////////////////////////////////////////

  logic signed [SMP_W:0] sum_a;  // One guard bit
  logic signed [SMP_W:0] sum_b;
  sample_pair_t          mix_q;

  assign sum_a = (SMP_W+1)'(adc_smp_i.ch_a) + (SMP_W+1)'(cfg_i.level_a);
  assign sum_b = (SMP_W+1)'(adc_smp_i.ch_b) + (SMP_W+1)'(cfg_i.level_b);

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      mix_q <= '0;
    end else begin
      mix_q.ch_a <= sat14(sum_a);
      mix_q.ch_b <= sat14(sum_b);
    end
  end

  assign mix_smp_o = mix_q;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Output sign follows the true sum, so no wrap-around ever leaks out
  a_no_wrap: assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    $past(adc_rstn) |->
      (mix_smp_o.ch_a[SMP_W-1] == $past(sum_a[SMP_W])) &&
      (mix_smp_o.ch_b[SMP_W-1] == $past(sum_b[SMP_W]))
  ) else $error("dac_mixer: output sign disagrees with the unclamped sum");

endmodule

//--- design/dac_output.sv
// DAC output stage.
// Each channel keeps a moving-average history of 2^AVG_LOG2 samples and a
// running sum that adds the newest sample and drops the oldest. The channel
// mode picks the plain mixer sample or the averaged one, which is turned back
// into negative-slope form and registered for the DAC pins.
module dac_output import rp_pkg::*; #(
  parameter int AVG_LOG2 = 6  // Window of 2..256 samples
) (
  input  logic             adc_clk,
  input  logic             adc_rstn,
  input  cfg_t             cfg_i,
  input  sample_pair_t     mix_smp_i,
  output logic [SMP_W-1:0] dac_a_o,  // Negative-slope code
  output logic [SMP_W-1:0] dac_b_o
);

  localparam int DEPTH = 2 ** AVG_LOG2;
  localparam int SUM_W = SMP_W + AVG_LOG2;  // Room for a full window

  ////////////////////////////////////////
  // Channel arrays
  ////////////////////////////////////////

  sample_t              smp_in [2];
  out_mode_e            mode   [2];
  logic [SMP_W-1:0]     dac_q  [2];
  logic [AVG_LOG2-1:0]  wr_idx;  // Shared by both histories

  assign smp_in[0] = mix_smp_i.ch_a;
  assign smp_in[1] = mix_smp_i.ch_b;
  assign mode[0]   = cfg_i.mode_a;
  assign mode[1]   = cfg_i.mode_b;

  // Wraps naturally at the window size
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      wr_idx <= '0;
    end else begin
      wr_idx <= wr_idx + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Per-channel average and output
  ////////////////////////////////////////

  for (genvar ch = 0; ch < 2; ch++) begin : g_ch
    sample_t [DEPTH-1:0]     hist;   // Last DEPTH samples
    logic signed [SUM_W-1:0] sum_q;
    logic signed [SUM_W-1:0] sum_d;  // Sum including this cycle's sample
    sample_t                 avg;
    sample_t                 sel;

    // New in, oldest out
    assign sum_d = sum_q + SUM_W'(smp_in[ch]) - SUM_W'(hist[wr_idx]);

    // Upper bits are the arithmetic shift by AVG_LOG2
    assign avg = sum_d[SUM_W-1:AVG_LOG2];

    assign sel = (mode[ch] == MODE_AVG) ? avg : smp_in[ch];

    // History runs in both modes, so a switch to averaging is seamless
    always_ff @(posedge adc_clk) begin
      if (!adc_rstn) begin
        hist  <= '0;
        sum_q <= '0;
      end else begin
        hist[wr_idx] <= smp_in[ch];
        sum_q        <= sum_d;
      end
    end

    always_ff @(posedge adc_clk) begin
      if (!adc_rstn) begin
        dac_q[ch] <= flip_slope('0);  // DAC idles at mid code
      end else begin
        dac_q[ch] <= flip_slope(sel);
      end
    end
  end

  assign dac_a_o = dac_q[0];
  assign dac_b_o = dac_q[1];

endmodule

//--- design/rp_dsp_top.sv
// Top level of the fast analog data path, all in the ADC clock domain.
// Input side is the ADC front end and the register block, the mixer adds the
// level registers, the output side averages and formats for the DAC.
// Pin to DAC latency is three cycles in pass mode.
module rp_dsp_top import rp_pkg::*; #(
  parameter logic [AXI_DW-1:0] ID_VALUE = 32'h5250_0001,
  parameter int                AVG_LOG2 = 6  // 64-sample window
) (
  input  logic                 adc_clk,
  input  logic                 adc_rstn,
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,
  input  axil_req_t            axil_req_i,
  output axil_rsp_t            axil_rsp_o,
  output logic [SMP_W-1:0]     dac_a_o,
  output logic [SMP_W-1:0]     dac_b_o
);

  cfg_t         cfg;
  sample_pair_t adc_smp;  // Front end to mixer
  sample_pair_t mix_smp;  // Mixer to output side and loopback

  axil_regs #(.ID_VALUE(ID_VALUE)) axil_regs_i (
    .adc_clk    (adc_clk),
    .adc_rstn   (adc_rstn),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .cfg_o      (cfg)
  );

  adc_frontend adc_frontend_i (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .cfg_i       (cfg),
    .mix_smp_i   (mix_smp),
    .adc_smp_o   (adc_smp)
  );

  dac_mixer dac_mixer_i (
    .adc_clk   (adc_clk),
    .adc_rstn  (adc_rstn),
    .cfg_i     (cfg),
    .adc_smp_i (adc_smp),
    .mix_smp_o (mix_smp)
  );

  dac_output #(.AVG_LOG2(AVG_LOG2)) dac_output_i (
    .adc_clk   (adc_clk),
    .adc_rstn  (adc_rstn),
    .cfg_i     (cfg),
    .mix_smp_i (mix_smp),
    .dac_a_o   (dac_a_o),
    .dac_b_o   (dac_b_o)
  );

endmodule

//--- tests/tb_rp_dsp.sv
// Testbench for the ADC to DAC data path top level.
// Random pin data and AXI4-Lite traffic run against a cycle model of the
// three-stage pipeline, compared with the DAC ports on every falling edge.
// Phases cover registers, pass mode, saturation, averaging, loopback and
// bus back-pressure.
module tb_rp_dsp import rp_pkg::*; ();

  localparam int              PERIOD   = 10;
  localparam int              AVG_LOG2 = 6;
  localparam int              DEPTH    = 1 << AVG_LOG2;
  localparam logic [31:0]     ID_VALUE = 32'h5250_0001;
  localparam logic [SMP_W-1:0] FLIP    = {1'b0, {(SMP_W-1){1'b1}}};  // Magnitude bits
  localparam int              SMAX     = 2 ** (SMP_W-1) - 1;
  localparam int              SMIN     = -(2 ** (SMP_W-1));
  localparam int PASS_LEN = 40;
  localparam int SAT_LEN  = 30;
  localparam int AVG_LEN  = 150;
  localparam int LOOP_LEN = 150;
  localparam int BUS_OPS  = 110;  // Rough count of register accesses
  localparam int OP_CYC   = 4;
  localparam int TEST_CYC = 16 + 8*PASS_LEN + 6*SAT_LEN + 2*AVG_LEN + 2*LOOP_LEN
                            + BUS_OPS*OP_CYC;
  localparam int MARGIN   = 500;

  logic                 adc_clk = 1'b0;
  logic                 adc_rstn;
  logic [ADC_RAW_W-1:0] adc_dat_a;
  logic [ADC_RAW_W-1:0] adc_dat_b;
  axil_req_t            req;
  axil_rsp_t            rsp;
  logic [SMP_W-1:0]     dac_a;
  logic [SMP_W-1:0]     dac_b;

  integer seed     = 32'hc906;
  integer errors   = 0;
  logic   check_on = 1'b0;
  logic   extreme  = 1'b0;  // Pins pick full-scale codes

  ////////////////////////////////////////
  // Model state
  ////////////////////////////////////////

  cfg_t         mdl_cfg;
  cfg_t         cfg_new;   // Write seen on the bus and applied at the next edge
  logic         cfg_pend = 1'b0;
  integer       adc_m  [2];
  integer       mix_m  [2];
  integer       sum_m  [2];
  integer       hist_m [2][DEPTH];
  integer       idx_m;
  sample_pair_t dac_m;

  always #(PERIOD/2) adc_clk = ~adc_clk;

  rp_dsp_top #(.ID_VALUE(ID_VALUE), .AVG_LOG2(AVG_LOG2)) rp_dsp_top_i (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .axil_req_i  (req),
    .axil_rsp_o  (rsp),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b)
  );

  // Top 14 pin bits with the sign kept and the rest flipped
  function automatic integer pin_to_int(input logic [ADC_RAW_W-1:0] w);
    logic [SMP_W-1:0] c;
    c = w[ADC_RAW_W-1:ADC_RAW_W-SMP_W] ^ FLIP;
    return 32'($signed(c));
  endfunction

  function automatic logic [SMP_W-1:0] to_dac(input integer v);
    return v[SMP_W-1:0] ^ FLIP;
  endfunction

  function automatic integer saturate(input integer s);
    if (s > SMAX) return SMAX;
    if (s < SMIN) return SMIN;
    return s;
  endfunction

  function automatic logic [31:0] exp_read(input logic [7:0] addr);
    case (addr)
      REG_ID:      return ID_VALUE;
      REG_CTRL:    return {29'd0, mdl_cfg.mode_b, mdl_cfg.mode_a, mdl_cfg.digital_loop};
      REG_LEVEL_A: return 32'(mdl_cfg.level_a);  // Sign-extended
      REG_LEVEL_B: return 32'(mdl_cfg.level_b);
      default:     return 32'd0;
    endcase
  endfunction

  // ID is readable but not writable
  function automatic logic [1:0] exp_resp(input logic [7:0] addr, input logic wr);
    if (addr inside {REG_CTRL, REG_LEVEL_A, REG_LEVEL_B} || (!wr && addr == REG_ID))
      return RESP_OKAY;
    return RESP_SLVERR;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_dac(input sample_pair_t exp, input sample_pair_t act);
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: dac_a_o,dac_b_o expected %h,%h got %h,%h", $time,
               exp.ch_a, exp.ch_b, act.ch_a, act.ch_b);
    end
  endtask

  task automatic check_rdata(input logic [AXI_DW-1:0] exp, input logic [AXI_DW-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: rdata expected %h got %h", $time, exp, act);
    end
  endtask

  task automatic check_resp(input logic [1:0] exp, input logic [1:0] act, input string name);
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_ready(input logic exp, input logic act, input string name);
    if (exp !== act) begin
      errors++;
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Pipeline model
  ////////////////////////////////////////

  always @(posedge adc_clk) begin
    integer           pin_v [2];
    integer           lvl   [2];
    logic             avg_v [2];
    logic [SMP_W-1:0] code  [2];
    integer           sum_d;
    integer           nmix;
    if (!adc_rstn) begin
      mdl_cfg = '0;
      idx_m   = 0;
      for (int ch = 0; ch < 2; ch++) begin
        adc_m[ch] = 0;
        mix_m[ch] = 0;
        sum_m[ch] = 0;
        for (int k = 0; k < DEPTH; k++) hist_m[ch][k] = 0;
      end
      dac_m = {to_dac(0), to_dac(0)};  // Mid code
    end else begin
      pin_v[0] = pin_to_int(adc_dat_a);
      pin_v[1] = pin_to_int(adc_dat_b);
      lvl[0]   = 32'(mdl_cfg.level_a);
      lvl[1]   = 32'(mdl_cfg.level_b);
      avg_v[0] = (mdl_cfg.mode_a == MODE_AVG);
      avg_v[1] = (mdl_cfg.mode_b == MODE_AVG);
      for (int ch = 0; ch < 2; ch++) begin
        sum_d = sum_m[ch] + mix_m[ch] - hist_m[ch][idx_m];  // Window slides by one
        code[ch] = to_dac(avg_v[ch] ? (sum_d >>> AVG_LOG2) : mix_m[ch]);
        hist_m[ch][idx_m] = mix_m[ch];
        sum_m[ch] = sum_d;
        nmix = saturate(adc_m[ch] + lvl[ch]);
        adc_m[ch] = mdl_cfg.digital_loop ? mix_m[ch] : pin_v[ch];
        mix_m[ch] = nmix;
      end
      dac_m = {code[0], code[1]};
      idx_m = (idx_m + 1) % DEPTH;
    end
    if (cfg_pend) begin
      mdl_cfg  = cfg_new;
      cfg_pend = 1'b0;
    end
  end

  // Output compare and write monitor on the falling edge
  always @(negedge adc_clk) begin
    if (check_on) check_dac(dac_m, {dac_a, dac_b});
    if (adc_rstn && rsp.awready) begin
      cfg_new = mdl_cfg;
      case (req.awaddr)
        REG_CTRL: begin
          cfg_new.digital_loop = req.wdata[0];
          cfg_new.mode_a       = out_mode_e'(req.wdata[1]);
          cfg_new.mode_b       = out_mode_e'(req.wdata[2]);
        end
        REG_LEVEL_A: cfg_new.level_a = req.wdata[SMP_W-1:0];
        REG_LEVEL_B: cfg_new.level_b = req.wdata[SMP_W-1:0];
        default: ;
      endcase
      cfg_pend = 1'b1;
    end
  end

  // Pin stimulus
  always @(posedge adc_clk) begin
    #1;
    if (extreme) begin
      adc_dat_a = (($random(seed) & 1) != 0) ? 16'hFFFC : 16'h0000;
      adc_dat_b = (($random(seed) & 1) != 0) ? 16'hFFFC : 16'h0000;
    end else begin
      adc_dat_a = 16'($random(seed));
      adc_dat_b = 16'($random(seed));
    end
  end

  ////////////////////////////////////////
  // AXI4-Lite driver
  ////////////////////////////////////////

  task automatic wr_check(input logic [7:0] addr, input logic [31:0] data);
    @(posedge adc_clk);
    #1;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    req.awaddr  = addr;
    req.wdata   = data;
    req.wstrb   = '1;
    req.bready  = 1'b1;
    @(negedge adc_clk);
    while (!rsp.awready) @(negedge adc_clk);
    check_ready(1'b1, rsp.wready, "wready");  // Pulses with awready
    @(posedge adc_clk);
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    @(negedge adc_clk);
    check_ready(1'b0, rsp.wready, "wready");
    while (!rsp.bvalid) @(negedge adc_clk);
    check_resp(exp_resp(addr, 1'b1), rsp.bresp, "bresp");
  endtask

  task automatic rd_check(input logic [7:0] addr);
    @(posedge adc_clk);
    #1;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    req.rready  = 1'b1;
    @(negedge adc_clk);
    while (!rsp.arready) @(negedge adc_clk);
    @(posedge adc_clk);
    #1;
    req.arvalid = 1'b0;
    @(negedge adc_clk);
    while (!rsp.rvalid) @(negedge adc_clk);
    check_rdata(exp_read(addr), rsp.rdata);
    check_resp(exp_resp(addr, 1'b0), rsp.rresp, "rresp");
  endtask

  // Second write queued behind a write held by low bready
  task automatic bp_write;
    logic [31:0] d2;
    d2 = $random(seed);
    @(posedge adc_clk);
    #1;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    req.awaddr  = REG_LEVEL_A;
    req.wdata   = $random(seed);
    req.bready  = 1'b0;
    @(negedge adc_clk);
    while (!rsp.awready) @(negedge adc_clk);
    @(posedge adc_clk);
    #1;
    req.awaddr = REG_LEVEL_B;
    req.wdata  = d2;
    repeat (6) begin
      @(negedge adc_clk);
      if (!rsp.bvalid || rsp.awready || rsp.wready) begin
        errors++;
        $display("Write response lost or second write taken early at %0t", $time);
      end
    end
    check_resp(RESP_OKAY, rsp.bresp, "bresp");
    @(posedge adc_clk);
    #1;
    req.bready = 1'b1;
    @(negedge adc_clk);
    while (!rsp.awready) @(negedge adc_clk);
    check_ready(1'b1, rsp.wready, "wready");
    @(posedge adc_clk);
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    @(negedge adc_clk);
    while (!rsp.bvalid) @(negedge adc_clk);
    check_resp(RESP_OKAY, rsp.bresp, "bresp");
    rd_check(REG_LEVEL_A);
    rd_check(REG_LEVEL_B);
  endtask

  // Read data held steady while rready is low
  task automatic bp_read;
    logic [31:0] held;
    @(posedge adc_clk);
    #1;
    req.arvalid = 1'b1;
    req.araddr  = REG_LEVEL_A;
    req.rready  = 1'b0;
    @(negedge adc_clk);
    while (!rsp.arready) @(negedge adc_clk);
    @(posedge adc_clk);
    #1;
    req.araddr = REG_CTRL;  // Second read waits
    held = exp_read(REG_LEVEL_A);
    repeat (6) begin
      @(negedge adc_clk);
      if (!rsp.rvalid || rsp.arready) begin
        errors++;
        $display("Read response lost or second read taken early at %0t", $time);
      end
      check_rdata(held, rsp.rdata);
    end
    @(posedge adc_clk);
    #1;
    req.rready = 1'b1;
    @(negedge adc_clk);
    while (!rsp.arready) @(negedge adc_clk);
    @(posedge adc_clk);
    #1;
    req.arvalid = 1'b0;
    @(negedge adc_clk);
    while (!rsp.rvalid) @(negedge adc_clk);
    check_rdata(exp_read(REG_CTRL), rsp.rdata);
    check_resp(RESP_OKAY, rsp.rresp, "rresp");
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    integer i;
    adc_rstn  = 1'b0;
    req       = '0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    @(posedge adc_clk);
    check_on = 1'b1;
    repeat (15) @(posedge adc_clk);  // 16 cycles in reset
    #1;
    adc_rstn = 1'b1;

    rd_check(REG_ID);
    for (i = 0; i < 24; i++) begin
      wr_check(8'(4 + 4*(i%3)), $random(seed));  // Cycles through CTRL and both levels
      rd_check(8'(4 + 4*(i%3)));
    end
    wr_check(8'h10, $random(seed));
    rd_check(8'h10);
    wr_check(REG_ID, 32'hFFFF_FFFF);
    rd_check(REG_ID);

    wr_check(REG_CTRL, 32'd0);  // Pass mode with random levels
    for (i = 0; i < 8; i++) begin
      wr_check(REG_LEVEL_A, $random(seed));
      wr_check(REG_LEVEL_B, $random(seed));
      repeat (PASS_LEN) @(posedge adc_clk);
    end

    extreme = 1'b1;  // Levels near the rails
    for (i = 0; i < 6; i++) begin
      wr_check(REG_LEVEL_A, (i % 2 == 0) ? SMAX - ($random(seed) & 15)
                                         : SMIN + ($random(seed) & 15));
      wr_check(REG_LEVEL_B, (i % 2 == 0) ? SMIN + ($random(seed) & 15)
                                         : SMAX - ($random(seed) & 15));
      repeat (SAT_LEN) @(posedge adc_clk);
    end
    extreme = 1'b0;

    wr_check(REG_LEVEL_A, $random(seed) & 32'h3FF);
    wr_check(REG_CTRL, 32'd2);  // Channel A averages first
    repeat (AVG_LEN) @(posedge adc_clk);
    wr_check(REG_CTRL, 32'd6);
    repeat (AVG_LEN) @(posedge adc_clk);

    wr_check(REG_LEVEL_A, 200 + ($random(seed) & 255));
    wr_check(REG_LEVEL_B, -200 - ($random(seed) & 255));
    wr_check(REG_CTRL, 32'd1);  // Loopback ramps to the rails
    repeat (LOOP_LEN) @(posedge adc_clk);
    wr_check(REG_CTRL, 32'd7);
    repeat (LOOP_LEN) @(posedge adc_clk);
    wr_check(REG_CTRL, 32'd0);

    bp_write();
    bp_read();
    repeat (4) @(posedge adc_clk);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the phase lengths
  initial begin
    #((TEST_CYC + MARGIN) * PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("Regression failed");
    $finish;
  end

endmodule

//--- src.f
design/rp_pkg.sv
design/adc_frontend.sv
design/axil_regs.sv
design/dac_mixer.sv
design/dac_output.sv
design/rp_dsp_top.sv
tests/tb_rp_dsp.sv

//--- run.sh
#!/usr/bin/env bash
# Build the RTL and testbench with Verilator and run the simulation.
# Exit status is zero only when the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f src.f \
  --top-module tb_rp_dsp -o sim_rp_dsp \
  && ./obj_dir/sim_rp_dsp | tee /dev/stderr | grep -q "Regression passed" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation or build failed"; exit 1; }
